//--- all.f
+incdir+.
trace_pkg.sv
stage_tag_pipe.sv
trace_table.sv
credit_fifo.sv
pipe_trace_top.sv
tb_pipe_trace.sv

//--- credit_fifo.sv
`timescale 1ns/100ps
`include "trace_cfg.svh"

/* small circular fifo with a registered output gated by consumer credits
   writes while full are dropped, the caller watches full to flag it */

module credit_fifo #(
    parameter type payload_t = trace_pkg::trace_rec_t,
    parameter int  DEPTH     = `TRACE_FIFO_DEPTH,
    parameter int  CREDITS   = `TRACE_CREDITS
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     wr_valid,
    input  payload_t wr_data,
    output logic     full,
    input  logic     credit_return,
    output logic     rd_valid,
    output payload_t rd_data
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int CRD_W = $clog2(CREDITS + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    // credits the consumer still grants
    logic [CRD_W-1:0] credits;
    logic             empty;
    logic             send;
    logic             bypass;
    logic             push;
    logic             pop;

    // next slot, wraps for any depth
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign empty  = (count == '0);
    assign full   = (count == CNT_W'(DEPTH));
    // send needs a credit and something to send
    assign send   = (credits != '0) && (!empty || wr_valid);
    // empty buffer: incoming word goes straight to the output register
    assign bypass = send && empty;
    assign push   = wr_valid && !full && !bypass;
    assign pop    = send && !empty;

    //////////////////////////////////////////////////////////////////////
    // pointers, fill level and credits
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credits  <= CRD_W'(CREDITS);
            rd_valid <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count    <= count + CNT_W'(push) - CNT_W'(pop);
            // one credit spent per send, one back per return
            credits  <= credits - CRD_W'(send) + CRD_W'(credit_return);
            rd_valid <= send;
        end
    end

    // storage and output payload
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
        if (send) begin
            rd_data <= empty ? wr_data : mem[rd_ptr];
        end
    end

endmodule

//--- pipe_trace_top.sv
`timescale 1ns/100ps
`include "trace_cfg.svh"

/* trace unit top, sits beside a five-stage pipeline as a passive observer
   streams one record per retired instruction, never stalls the pipeline */

module pipe_trace_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   stall,
    input  logic                   flush,
    input  trace_pkg::stage_data_t stage_data,
    input  logic                   credit_return,
    output logic                   rec_valid,
    output trace_pkg::trace_rec_t  rec,
    output logic                   overflow
);
    import trace_pkg::*;

    // free-running stamp source, 0 in the first cycle out of reset
    logic [`TRACE_CYC_W-1:0] cycle;
    stage_tags_t             tags;
    stage_adv_t              adv;
    logic                    wr_valid;
    trace_rec_t              wr_rec;
    logic                    fifo_full;

    always_ff @(posedge clk) begin
        if (rst) begin
            cycle    <= '0;
            overflow <= 1'b0;
        end else begin
            cycle <= cycle + 1'b1;
            // sticky, a record was lost
            if (wr_valid && fifo_full) begin
                overflow <= 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // tag pipe -> record table -> credit fifo
    //////////////////////////////////////////////////////////////////////

    stage_tag_pipe u_tags (
        .clk   (clk),
        .rst   (rst),
        .stall (stall),
        .flush (flush),
        .tags  (tags),
        .adv   (adv)
    );

    trace_table u_table (
        .clk        (clk),
        .rst        (rst),
        .tags       (tags),
        .adv        (adv),
        .stage_data (stage_data),
        .cycle      (cycle),
        .wr_valid   (wr_valid),
        .wr_rec     (wr_rec)
    );

    credit_fifo #(
        .payload_t (trace_rec_t)
    ) u_fifo (
        .clk           (clk),
        .rst           (rst),
        .wr_valid      (wr_valid),
        .wr_data       (wr_rec),
        .full          (fifo_full),
        .credit_return (credit_return),
        .rd_valid      (rec_valid),
        .rd_data       (rec)
    );

endmodule

//--- stage_tag_pipe.sv
`timescale 1ns/100ps

/* id and valid tag tracker that walks beside the five cpu stages
   applies stall and flush so downstream logic only sees per-stage advance bits */

module stage_tag_pipe (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   stall,
    input  logic                   flush,
    output trace_pkg::stage_tags_t tags,
    output trace_pkg::stage_adv_t  adv
);
    import trace_pkg::*;

    // id handed to the next fetched instruction
    id_t  next_id;
    // fetch and decode may move on
    logic front_move;

    //////////////////////////////////////////////////////////////////////
    // advance bits
    //////////////////////////////////////////////////////////////////////

    // flush wins over stall, both freeze the front
    assign front_move = !stall && !flush;

    always_comb begin
        // front half leaves only when not held or killed
        adv[STG_IF] = tags[STG_IF].valid && front_move;
        adv[STG_ID] = tags[STG_ID].valid && front_move;
        // back half never stalls
        for (int s = STG_EX; s < NUM_STAGES; s++) begin
            adv[s] = tags[s].valid;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // tag registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            next_id <= '0;
            // all slots empty out of reset
            tags    <= '0;
        end else begin
            // memory and write-back always take from the stage before
            for (int s = STG_MEM; s < NUM_STAGES; s++) begin
                tags[s] <= tags[s-1];
            end

            if (flush) begin
                // kill fetch and decode
                tags[STG_IF].valid <= 1'b0;
                tags[STG_ID].valid <= 1'b0;
                // decode was killed so execute gets nothing
                tags[STG_EX].valid <= 1'b0;
                // id counter holds, killed ids are simply skipped
            end else if (stall) begin
                // fetch and decode hold their tags
                // bubble into execute
                tags[STG_EX].valid <= 1'b0;
            end else begin
                // new fetch every unstalled cycle
                tags[STG_IF] <= '{valid: 1'b1, id: next_id};
                tags[STG_ID] <= tags[STG_IF];
                tags[STG_EX] <= tags[STG_ID];
                // ids wrap at 8
                next_id      <= next_id + 1'b1;
            end
        end
    end

endmodule

//--- tb_pipe_trace.sv
`timescale 1ns/100ps
`include "trace_cfg.svh"

/* self-checking testbench for the pipeline trace unit
   models the cpu pipeline and a credit-returning consumer and checks every record in order */

module tb_pipe_trace;
    import trace_pkg::*;

    localparam int NUM_IDS    = 1 << `TRACE_ID_W;
    localparam int PHASE_LEN  = 300;
    // four phases of PHASE_LEN plus the overflow phase and margin
    localparam int MAX_CYCLES = 5 * PHASE_LEN + 500;

    logic        clk, rst, stall, flush, credit_return, rec_valid, overflow;
    stage_data_t stage_data;
    trace_rec_t  rec;

    // stimulus knobs only change on the falling edge
    int          stall_pct, flush_pct;
    int          credit_mode;   // 0 withhold, 1 return at once, 2 return at random
    logic        throttle, allow_ovf, seen_ovf;
    // pipeline model with one slot per stage
    logic [4:0]  sv;
    id_t         sid [5];
    id_t         nid;
    trace_rec_t  part [NUM_IDS];
    int          held [NUM_IDS];
    logic [NUM_IDS-1:0] killed;
    trace_rec_t  exp_q [$];
    int          held_q [$];
    int          cyc, owed, rec_count, base, ticks;
    logic [31:0] rng;

    pipe_trace_top uut (
        .clk           (clk),
        .rst           (rst),
        .stall         (stall),
        .flush         (flush),
        .stage_data    (stage_data),
        .credit_return (credit_return),
        .rec_valid     (rec_valid),
        .rec           (rec),
        .overflow      (overflow)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic chance(input int pct);
        rng = xorshift(rng);
        return (rng % 100) < pct;
    endfunction

    // stage number in the top nibble and the cycle spread over the rest
    function automatic word_t stage_word(input int s, input int c);
        return {4'(s + 1), 12'(c * 3), 16'(c)};
    endfunction

    task automatic stop_run();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [159:0] got,
                               input logic [159:0] exp);
        assert (got === exp) else begin
            $display("Error %s got %h expected %h", name, got, exp);
            stop_run();
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // pipeline model
    ////////////////////////////////////////////////////////////////////

    // stamp and word of a stage are taken in the cycle the instruction leaves it
    task automatic capture_stage(input int s, input id_t id);
        case (s)
            STG_IF: begin
                part[id].data.pc     = stage_data.pc;
                part[id].stamp.fetch = cyc;
            end
            STG_ID: begin
                part[id].data.instr   = stage_data.instr;
                part[id].stamp.decode = cyc;
            end
            STG_EX: begin
                part[id].data.alu      = stage_data.alu;
                part[id].stamp.execute = cyc;
            end
            STG_MEM: begin
                part[id].data.mem_data = stage_data.mem_data;
                part[id].stamp.memory  = cyc;
            end
            default: begin
                part[id].data.wb_data = stage_data.wb_data;
                part[id].stamp.wb     = cyc;
                part[id].id           = id;
                exp_q.push_back(part[id]);
                held_q.push_back(held[id]);
            end
        endcase
    endtask

    task automatic model_step();
        for (int s = 0; s < NUM_STAGES; s++) begin
            if (sv[s] && (s >= STG_EX || (!stall && !flush))) begin
                capture_stage(s, sid[s]);
            end
        end
        // stall cycles spent waiting in decode stretch fetch to write-back
        if (sv[STG_ID] && stall && !flush) begin
            held[sid[STG_ID]]++;
        end
        for (int s = 0; s < 2; s++) begin
            if (flush && sv[s]) begin
                killed[sid[s]] = 1'b1;
            end
        end
        sv[4]  = sv[3];
        sid[4] = sid[3];
        sv[3]  = sv[2];
        sid[3] = sid[2];
        if (flush) begin
            sv[2:0] = '0;
        end else if (stall) begin
            // bubble into execute
            sv[2] = 1'b0;
        end else begin
            sv[2]       = sv[1];
            sid[2]      = sid[1];
            sv[1]       = sv[0];
            sid[1]      = sid[0];
            sv[0]       = 1'b1;
            sid[0]      = nid;
            killed[nid] = 1'b0;
            held[nid]   = 0;
            nid++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // output checks, consumer and input drive
    ////////////////////////////////////////////////////////////////////

    task automatic check_outputs();
        trace_rec_t e;
        int         hd;
        if (cyc == 0) begin
            check_value("rec_valid", rec_valid, 1'b0);
        end
        if (!allow_ovf) begin
            check_value("overflow", overflow, 1'b0);
        end
        if (seen_ovf) begin
            check_value("overflow", overflow, 1'b1);
        end
        seen_ovf = seen_ovf | overflow;
        if (rec_valid) begin
            assert (owed < `TRACE_CREDITS) else begin
                $display("record sent while the consumer had granted no credit");
                stop_run();
            end
            assert (exp_q.size() != 0) else begin
                $display("record sent with no retired instruction waiting");
                stop_run();
            end
            assert (!killed[rec.id]) else begin
                $display("record delivered for a flushed instruction");
                stop_run();
            end
            e  = exp_q.pop_front();
            hd = held_q.pop_front();
            if (rec_count == 0) begin
                check_value("rec.id", rec.id, 0);
            end
            check_value("rec.id", rec.id, e.id);
            check_value("rec.data", rec.data, e.data);
            check_value("rec.stamp", rec.stamp, e.stamp);
            check_value("rec.stamp.wb - rec.stamp.fetch",
                        cyc_t'(rec.stamp.wb - rec.stamp.fetch), cyc_t'(4 + hd));
            owed++;
            rec_count++;
        end
    endtask

    always @(posedge clk) begin : step
        stage_data_t nd;
        if (rst) begin
            cyc    = 0;
            nid    = '0;
            sv     = '0;
            killed = '0;
        end else begin
            check_outputs();
            model_step();
            cyc++;
        end
        nd.pc       = stage_word(0, cyc);
        nd.instr    = stage_word(1, cyc);
        nd.alu      = stage_word(2, cyc);
        nd.mem_data = stage_word(3, cyc);
        nd.wb_data  = stage_word(4, cyc);
        stage_data <= nd;
        // throttle keeps at most TRACE_FIFO_DEPTH records outstanding
        stall <= chance(stall_pct) || (throttle && exp_q.size() != 0);
        flush <= chance(flush_pct);
        if (owed > 0 && (credit_mode == 1 || (credit_mode == 2 && chance(50)))) begin
            credit_return <= 1'b1;
            owed--;
        end else begin
            credit_return <= 1'b0;
        end
    end

    always @(posedge clk) begin
        ticks++;
        assert (ticks < MAX_CYCLES) else begin
            $display("timeout, the run did not end within %0d cycles", MAX_CYCLES);
            stop_run();
        end
    end

    initial begin
        rst           = 1'b1;
        stall         = 1'b0;
        flush         = 1'b0;
        credit_return = 1'b0;
        stage_data    = '0;
        stall_pct     = 0;
        flush_pct     = 0;
        credit_mode   = 1;
        throttle      = 1'b1;
        allow_ovf     = 1'b0;
        seen_ovf      = 1'b0;
        owed          = 0;
        rec_count     = 0;
        base          = 0;
        ticks         = 0;
        rng           = 32'hb5b4_1c74;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        // clean stream followed by random stalls and then flushes
        repeat (PHASE_LEN) @(negedge clk);
        stall_pct   = 30;
        credit_mode = 2;
        repeat (PHASE_LEN) @(negedge clk);
        stall_pct   = 20;
        flush_pct   = 15;
        credit_mode = 1;
        repeat (PHASE_LEN) @(negedge clk);
        // short credit droughts keep the backlog within the fifo
        stall_pct = 10;
        flush_pct = 5;
        for (int i = 0; i < PHASE_LEN / 30; i++) begin
            credit_mode = 0;
            repeat (15) @(negedge clk);
            credit_mode = 1;
            repeat (15) @(negedge clk);
        end
        // drain everything and then starve the consumer until records drop
        stall_pct = 100;
        flush_pct = 0;
        repeat (10) @(negedge clk);
        while (exp_q.size() != 0 || owed != 0) @(negedge clk);
        base        = rec_count;
        credit_mode = 0;
        stall_pct   = 0;
        throttle    = 1'b0;
        allow_ovf   = 1'b1;
        repeat (30) @(negedge clk);
        stall_pct = 100;
        repeat (10) @(negedge clk);
        check_value("overflow", overflow, 1'b1);
        check_value("records sent without credits", rec_count - base, `TRACE_CREDITS);
        base        = rec_count;
        credit_mode = 1;
        repeat (20) @(negedge clk);
        // only the oldest fifo entries come out since the rest were dropped
        if (rec_count - base == `TRACE_FIFO_DEPTH) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("overflow phase did not deliver exactly the oldest buffered records");
            stop_run();
        end
    end

endmodule

//--- trace_cfg.svh
/* sizing macros for the pipeline trace unit
   include wherever an id width, stamp width, fifo depth or credit count is needed */

`ifndef TRACE_CFG_SVH
`define TRACE_CFG_SVH

// instruction id width
// 8 ids in use, at most 5 in flight across the stages
`define TRACE_ID_W 3

// cycle stamp width, wraps silently
`define TRACE_CYC_W 16

// retired records buffered ahead of the consumer
`define TRACE_FIFO_DEPTH 4

// records the consumer can take before it must return a credit
`define TRACE_CREDITS 2

`endif

//--- trace_pkg.sv
/* shared types of the pipeline trace unit
   stage words, stage tags, cycle stamps and the retired trace record */

`include "trace_cfg.svh"

package trace_pkg;

    // stage indices, fetch first
    localparam int STG_IF     = 0;
    localparam int STG_ID     = 1;
    localparam int STG_EX     = 2;
    localparam int STG_MEM    = 3;
    localparam int STG_WB     = 4;
    localparam int NUM_STAGES = 5;

    typedef logic [`TRACE_ID_W-1:0]  id_t;
    typedef logic [`TRACE_CYC_W-1:0] cyc_t;
    typedef logic [31:0]             word_t;

    // one data word per stage, 160 bits
    typedef struct packed {
        word_t pc;
        word_t instr;
        word_t alu;
        word_t mem_data;
        word_t wb_data;
    } stage_data_t;

    // valid bit plus instruction id
    typedef struct packed {
        logic valid;
        id_t  id;
    } stage_tag_t;

    typedef stage_tag_t [NUM_STAGES-1:0] stage_tags_t;

    // bit set = instruction in that stage leaves it this cycle
    typedef logic [NUM_STAGES-1:0] stage_adv_t;

    // cycle stamp taken when the instruction leaves each stage
    typedef struct packed {
        cyc_t fetch;
        cyc_t decode;
        cyc_t execute;
        cyc_t memory;
        cyc_t wb;
    } stage_stamps_t;

    // retired record, 243 bits
    typedef struct packed {
        id_t           id;
        stage_data_t   data;
        stage_stamps_t stamp;
    } trace_rec_t;

endpackage

//--- trace_table.sv
`timescale 1ns/100ps
`include "trace_cfg.svh"

/* per-id record table filled stage by stage as instructions advance
   emits the finished trace record one cycle after write-back */

module trace_table (
    input  logic                    clk,
    input  logic                    rst,
    input  trace_pkg::stage_tags_t  tags,
    input  trace_pkg::stage_adv_t   adv,
    input  trace_pkg::stage_data_t  stage_data,
    input  logic [`TRACE_CYC_W-1:0] cycle,
    output logic                    wr_valid,
    output trace_pkg::trace_rec_t   wr_rec
);
    import trace_pkg::*;

    localparam int NUM_IDS = 1 << `TRACE_ID_W;

    // partial records, one per id
    trace_rec_t entry [NUM_IDS];
    // record retiring this cycle
    trace_rec_t done_rec;

    //////////////////////////////////////////////////////////////////////
    // stage capture
    //////////////////////////////////////////////////////////////////////

    // each stage writes only into its own instruction's entry
    always_ff @(posedge clk) begin
        if (adv[STG_IF]) begin
            entry[tags[STG_IF].id].data.pc      <= stage_data.pc;
            entry[tags[STG_IF].id].stamp.fetch  <= cycle;
        end
        if (adv[STG_ID]) begin
            entry[tags[STG_ID].id].data.instr   <= stage_data.instr;
            entry[tags[STG_ID].id].stamp.decode <= cycle;
        end
        if (adv[STG_EX]) begin
            entry[tags[STG_EX].id].data.alu       <= stage_data.alu;
            entry[tags[STG_EX].id].stamp.execute  <= cycle;
        end
        if (adv[STG_MEM]) begin
            entry[tags[STG_MEM].id].data.mem_data <= stage_data.mem_data;
            entry[tags[STG_MEM].id].stamp.memory  <= cycle;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // retirement
    //////////////////////////////////////////////////////////////////////

    // stored front fields plus write-back fields of this very cycle
    always_comb begin
        done_rec              = entry[tags[STG_WB].id];
        done_rec.id           = tags[STG_WB].id;
        done_rec.data.wb_data = stage_data.wb_data;
        done_rec.stamp.wb     = cycle;
    end

    // one pulse per retired instruction
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_valid <= 1'b0;
        end else begin
            wr_valid <= adv[STG_WB];
        end
    end

    always_ff @(posedge clk) begin
        if (adv[STG_WB]) begin
            wr_rec <= done_rec;
        end
    end

endmodule
